// ==== hdl/uartBusPkg.sv ====
// shared widths and status layouts; both record kinds keep their 2-bit tag in bits 31:30
`default_nettype none

package uartBusPkg;

	localparam int addrWidth = 16; // cpu and data memory byte address
	localparam int dataWidth = 32; // one data memory word

	// channel address map, channel i starts at uartBase + i * chanStride
	localparam logic [addrWidth-1:0] chanStride = 16'd16;
	localparam logic [addrWidth-1:0] offTxData = 16'd0; // cpu store starts a transmission
	localparam logic [addrWidth-1:0] offRxFlag = 16'd4; // receive record lands here
	localparam logic [addrWidth-1:0] offTxFlag = 16'd12; // transmit-done record lands here

	localparam logic [1:0] tagRx = 2'b01;
	localparam logic [1:0] tagTxDone = 2'b10;

	typedef struct packed {
		logic [1:0] tag;
		logic overrun; // an unwritten byte was replaced
		logic [20:0] reserved;
		logic [7:0] rxByte;
	} rxRecord;

	typedef struct packed {
		logic [1:0] tag;
		logic [21:0] reserved;
		logic [7:0] sentCount; // completions since reset, wraps
	} txRecord;

	// one memory word seen as either record or as raw data
	typedef union packed {
		rxRecord rx;
		txRecord tx;
		logic [dataWidth-1:0] raw;
	} statusWord;

endpackage

`default_nettype wire

// ==== hdl/uartChanIf.sv ====
// one channel's link between decoder, tracker and arbiter; grant is a single-cycle strobe
`timescale 1ns/10ps
`default_nettype none

interface uartChanIf;

	logic txStart; // registered start strobe from the decoder
	logic [7:0] txByte; // shared transmit byte
	logic txIdle; // busy low and no transmit-done record waiting
	logic req; // a record is pending
	uartBusPkg::statusWord record;
	logic grant; // record taken this cycle

	modport decodePort (
		output txStart,
		output txByte,
		input txIdle
	);

	modport trackPort (
		input txStart,
		input txByte,
		input grant,
		output txIdle,
		output req,
		output record
	);

	modport drainPort (
		input req,
		input record,
		output grant
	);

endinterface

`default_nettype wire

// ==== hdl/cpuPortDecode.sv ====
// stores to a busy channel are dropped with no notice; the byte register is shared by all channels
`timescale 1ns/10ps
`default_nettype none

module cpuPortDecode #(
	parameter int numUarts = 2,
	parameter logic [uartBusPkg::addrWidth-1:0] uartBase = 16'h0400
) (
	input logic clk,
	input logic rstN,
	input logic [uartBusPkg::addrWidth-1:0] cpuAddress,
	input logic cpuWrite,
	input logic [7:0] cpuWriteData,
	uartChanIf.decodePort chan [numUarts]
);

	localparam int aw = uartBusPkg::addrWidth;

	logic [numUarts-1:0] hit; // store accepted per channel
	logic [numUarts-1:0] startQ;
	logic [7:0] byteQ;

	for (genvar g = 0; g < numUarts; g++) begin : gChan
		localparam logic [aw-1:0] txAddr = uartBase + aw'(g) * uartBusPkg::chanStride
			+ uartBusPkg::offTxData;

		assign hit[g] = cpuWrite && (cpuAddress == txAddr) && chan[g].txIdle;
		assign chan[g].txStart = startQ[g];
		assign chan[g].txByte = byteQ;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			startQ <= '0;
			byteQ <= '0;
		end else begin
			startQ <= hit; // one-hot, addresses are distinct
			if (|hit) begin
				byteQ <= cpuWriteData; // held until the next accepted store
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uartChanTracker.sv ====
// one record of each kind can wait; a newer receive byte overwrites the waiting one and flags overrun
`timescale 1ns/10ps
`default_nettype none

module uartChanTracker (
	input logic clk,
	input logic rstN,
	input logic rxReady,
	input logic [7:0] rxByte,
	input logic txBusy,
	output logic txStart,
	output logic [7:0] txByte,
	uartChanIf.trackPort chan
);

	logic rxPrev;
	logic busyPrev;
	logic rxRise;
	logic txFall;
	logic grantRx;
	logic grantTx;
	logic rxPend;
	logic txPend;
	logic overrun;
	logic [7:0] rxData;
	logic [7:0] sentCount;
	uartBusPkg::statusWord recWord;

	assign rxRise = rxReady && !rxPrev;
	assign txFall = busyPrev && !txBusy; // transmission finished
	assign grantTx = chan.grant && txPend; // tx-done is the record on offer when both wait
	assign grantRx = chan.grant && !txPend;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rxPrev <= 1'b0;
			busyPrev <= 1'b0;
			rxPend <= 1'b0;
			txPend <= 1'b0;
			overrun <= 1'b0;
			sentCount <= '0;
		end else begin
			rxPrev <= rxReady;
			busyPrev <= txBusy;
			if (txFall) begin
				txPend <= 1'b1; // stays set even when the old record is granted now
				sentCount <= sentCount + 8'd1;
			end else if (grantTx) begin
				txPend <= 1'b0;
			end
			if (rxRise) begin
				rxPend <= 1'b1;
				overrun <= rxPend && !grantRx; // old byte lost only if it was never written
			end else if (grantRx) begin
				rxPend <= 1'b0;
				overrun <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rxRise) begin
			rxData <= rxByte;
		end
	end

	always_comb begin
		recWord = '0;
		if (txPend) begin
			recWord.tx.tag = uartBusPkg::tagTxDone;
			recWord.tx.sentCount = sentCount;
		end else begin
			recWord.rx.tag = uartBusPkg::tagRx;
			recWord.rx.overrun = overrun;
			recWord.rx.rxByte = rxData;
		end
	end

	assign chan.record = recWord;
	assign chan.req = rxPend || txPend;
	assign chan.txIdle = !txBusy && !txPend;
	assign txStart = chan.txStart; // on to the serializer
	assign txByte = chan.txByte;

endmodule

`default_nettype wire

// ==== hdl/flagWriteArbiter.sv ====
// grants only on cycles with cpuRead and cpuWrite low; fixed order is tx-done first, then low index
`timescale 1ns/10ps
`default_nettype none

module flagWriteArbiter #(
	parameter int numUarts = 2,
	parameter logic [uartBusPkg::addrWidth-1:0] uartBase = 16'h0400
) (
	input logic clk,
	input logic rstN,
	input logic cpuRead,
	input logic cpuWrite,
	uartChanIf.drainPort chan [numUarts],
	output logic memWrite,
	output logic [uartBusPkg::addrWidth-1:0] memAddress,
	output logic [uartBusPkg::dataWidth-1:0] memWriteData
);

	localparam int aw = uartBusPkg::addrWidth;
	localparam int idxW = (numUarts > 1) ? $clog2(numUarts) : 1;

	logic [numUarts-1:0] reqV;
	logic [numUarts-1:0] isTx;
	logic [numUarts-1:0] grantVec; // one-hot or zero
	uartBusPkg::statusWord words [numUarts];
	uartBusPkg::statusWord selWord;
	logic busIdle;
	logic hasTx;
	logic selValid;
	logic [idxW-1:0] selIdx;

	assign busIdle = !cpuRead && !cpuWrite;

	for (genvar g = 0; g < numUarts; g++) begin : gChan
		assign reqV[g] = chan[g].req;
		assign isTx[g] = (chan[g].record.tx.tag == uartBusPkg::tagTxDone);
		assign words[g] = chan[g].record;
		assign grantVec[g] = busIdle && selValid && (selIdx == idxW'(g));
		assign chan[g].grant = grantVec[g];
	end

	assign hasTx = |(reqV & isTx);

	always_comb begin
		selValid = 1'b0;
		selIdx = '0;
		for (int i = numUarts - 1; i >= 0; i--) begin // downward, lowest index wins
			if (reqV[i] && (isTx[i] || !hasTx)) begin
				selValid = 1'b1;
				selIdx = idxW'(i);
			end
		end
	end

	assign selWord = words[selIdx];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWrite <= 1'b0;
			memAddress <= '0;
			memWriteData <= '0;
		end else begin
			memWrite <= |grantVec; // one cycle behind the grant
			if (|grantVec) begin
				memAddress <= uartBase + aw'(selIdx) * uartBusPkg::chanStride
					+ ((selWord.tx.tag == uartBusPkg::tagTxDone) ?
					uartBusPkg::offTxFlag : uartBusPkg::offRxFlag);
				memWriteData <= selWord.raw;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uartBusBridge.sv ====
// numUarts 1 to 8; memory writes are issued only on idle bus cycles and never stall
`timescale 1ns/10ps
`default_nettype none

module uartBusBridge #(
	parameter int numUarts = 2,
	parameter logic [uartBusPkg::addrWidth-1:0] uartBase = 16'h0400
) (
	input logic clk,
	input logic rstN,
	input logic [uartBusPkg::addrWidth-1:0] cpuAddress,
	input logic cpuWrite,
	input logic cpuRead,
	input logic [7:0] cpuWriteData,
	input logic [numUarts-1:0] uartRxReady,
	input logic [numUarts-1:0][7:0] uartRxByte,
	input logic [numUarts-1:0] uartTxBusy,
	output logic [numUarts-1:0] uartTxStart,
	output logic [7:0] uartTxByte,
	output logic memWrite,
	output logic [uartBusPkg::addrWidth-1:0] memAddress,
	output logic [uartBusPkg::dataWidth-1:0] memWriteData
);

	logic [7:0] fwdByte [numUarts]; // same byte on every channel

	uartChanIf chanIf [numUarts] ();

	cpuPortDecode #(
		.numUarts(numUarts),
		.uartBase(uartBase)
	) decode0 (
		.clk(clk),
		.rstN(rstN),
		.cpuAddress(cpuAddress),
		.cpuWrite(cpuWrite),
		.cpuWriteData(cpuWriteData),
		.chan(chanIf)
	);

	for (genvar g = 0; g < numUarts; g++) begin : gTrack
		uartChanTracker track (
			.clk(clk),
			.rstN(rstN),
			.rxReady(uartRxReady[g]),
			.rxByte(uartRxByte[g]),
			.txBusy(uartTxBusy[g]),
			.txStart(uartTxStart[g]),
			.txByte(fwdByte[g]),
			.chan(chanIf[g])
		);
	end

	assign uartTxByte = fwdByte[0];

	flagWriteArbiter #(
		.numUarts(numUarts),
		.uartBase(uartBase)
	) arb0 (
		.clk(clk),
		.rstN(rstN),
		.cpuRead(cpuRead),
		.cpuWrite(cpuWrite),
		.chan(chanIf),
		.memWrite(memWrite),
		.memAddress(memAddress),
		.memWriteData(memWriteData)
	);

endmodule

`default_nettype wire

// ==== verif/uartBusBridge_chk.sv ====
// bound into every flagWriteArbiter; checks only hold while rstN is high
`timescale 1ns/10ps
`default_nettype none

module uartBusBridgeChk #(
	parameter int numUarts = 2
) (
	input logic clk,
	input logic rstN,
	input logic cpuRead,
	input logic cpuWrite,
	input logic memWrite,
	input logic [numUarts-1:0] grantVec
);

	logic busBusy;

	assign busBusy = cpuRead || cpuWrite;

	noWriteAfterBusy: assert property (@(posedge clk) disable iff (!rstN)
		busBusy |=> !memWrite)
		else $error("memory write follows a busy bus cycle");

	oneGrant: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0(grantVec))
		else $error("more than one grant in a cycle");

	writeAfterGrant: assert property (@(posedge clk) disable iff (!rstN)
		(|grantVec) |=> memWrite)
		else $error("grant without a memory write");

	noWriteWithoutGrant: assert property (@(posedge clk) disable iff (!rstN)
		!(|grantVec) |=> !memWrite)
		else $error("memory write without a grant");

	noGrantBusy: assert property (@(posedge clk) disable iff (!rstN)
		busBusy |-> (grantVec == '0))
		else $error("grant while the cpu holds the bus");

endmodule

bind flagWriteArbiter uartBusBridgeChk #(.numUarts(numUarts)) chk0 (
	.clk(clk),
	.rstN(rstN),
	.cpuRead(cpuRead),
	.cpuWrite(cpuWrite),
	.memWrite(memWrite),
	.grantVec(grantVec)
);

`default_nettype wire

// ==== verif/uartBusBridgeTb.sv ====
// two channels at base 16'h0400; the expected records come from a cycle model evaluated at each falling edge
`timescale 1ns/10ps
`default_nettype none

module uartBusBridgeTb;

	localparam int nU = 2;
	localparam int aw = uartBusPkg::addrWidth;
	localparam logic [aw-1:0] base = 16'h0400;
	localparam int numTests = 6;
	localparam int resetCycles = 4;

	logic clk;
	logic rstN;
	logic [aw-1:0] cpuAddress;
	logic cpuWrite;
	logic cpuRead;
	logic [7:0] cpuWriteData;
	logic [nU-1:0] uartRxReady;
	logic [nU-1:0][7:0] uartRxByte;
	logic [nU-1:0] uartTxBusy = '0; // serializer model idle until the first start
	logic [nU-1:0] uartTxStart;
	logic [7:0] uartTxByte;
	logic memWrite;
	logic [aw-1:0] memAddress;
	logic [uartBusPkg::dataWidth-1:0] memWriteData;

	logic [15:0] lfsr = 16'd73;
	int busyCnt [nU];
	string curTest = "reset";
	int errors = 0;
	int passCount = 0;
	int failCount = 0;

	// reference model state, one entry per channel
	logic mRxPrev [nU];
	logic mBusyPrev [nU];
	logic mRxPend [nU];
	logic mTxPend [nU];
	logic mOvr [nU];
	logic [7:0] mRxData [nU];
	logic [7:0] mSent [nU];
	logic [nU-1:0] expStart = '0;
	logic [7:0] expByte = '0;
	logic expWrite = 1'b0;
	int orderQ [$]; // channel of each granted record, in grant order
	uartBusPkg::statusWord wordQ [nU][$];
	logic [aw-1:0] addrQ [nU][$];

	uartBusBridge dut0 (
		.clk(clk),
		.rstN(rstN),
		.cpuAddress(cpuAddress),
		.cpuWrite(cpuWrite),
		.cpuRead(cpuRead),
		.cpuWriteData(cpuWriteData),
		.uartRxReady(uartRxReady),
		.uartRxByte(uartRxByte),
		.uartTxBusy(uartTxBusy),
		.uartTxStart(uartTxStart),
		.uartTxByte(uartTxByte),
		.memWrite(memWrite),
		.memAddress(memAddress),
		.memWriteData(memWriteData)
	);

	always #20 clk = ~clk;

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 16'hB400; // galois taps 16,14,13,11
		end
		return s;
	endfunction

	task automatic drawBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[14:0], lfsr[0]}; // one step per bit
		end
	endtask

	function automatic logic [aw-1:0] txAddr(input int ch);
		return base + aw'(ch) * uartBusPkg::chanStride + uartBusPkg::offTxData;
	endfunction

	function automatic logic [aw-1:0] refAddr(input int ch, input logic isTx);
		return base + aw'(ch) * uartBusPkg::chanStride
			+ (isTx ? uartBusPkg::offTxFlag : uartBusPkg::offRxFlag);
	endfunction

	// expected status word from the record rules
	function automatic uartBusPkg::statusWord refRecord(input logic isTx, input logic ovr,
		input logic [7:0] val);
		uartBusPkg::statusWord w;
		w.raw = '0;
		if (isTx) begin
			w.tx.tag = uartBusPkg::tagTxDone;
			w.tx.sentCount = val;
		end else begin
			w.rx.tag = uartBusPkg::tagRx;
			w.rx.overrun = ovr;
			w.rx.rxByte = val;
		end
		return w;
	endfunction

	task automatic checkWord(input string what, input uartBusPkg::statusWord exp,
		input uartBusPkg::statusWord act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", curTest, what, exp.raw, act.raw);
		end
	endtask

	task automatic checkAddr(input string what, input logic [aw-1:0] exp,
		input logic [aw-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic checkStart(input logic [nU-1:0] exp, input logic [nU-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s uartTxStart: expected %b, actual %b", curTest, exp, act);
		end
	endtask

	task automatic checkByte(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s uartTxByte: expected %h, actual %h", curTest, exp, act);
		end
	endtask

	task automatic compareStep();
		int ch;
		checkStart(expStart, uartTxStart);
		if (|expStart) begin
			checkByte(expByte, uartTxByte);
		end
		if (memWrite) begin
			if (orderQ.size() == 0) begin
				errors++;
				$display("%s: memory write at %h with no record expected", curTest, memAddress);
			end else begin
				ch = orderQ.pop_front();
				checkWord("memWriteData", wordQ[ch].pop_front(), memWriteData);
				checkAddr("memAddress", addrQ[ch].pop_front(), memAddress);
			end
		end else if (expWrite) begin
			errors++;
			$display("%s: an expected memory write did not happen", curTest);
		end
	endtask

	// predicts the next rising edge from the inputs that edge will sample
	task automatic modelStep();
		logic idle;
		logic gTx;
		logic rise;
		logic fall;
		int gch;
		idle = !cpuRead && !cpuWrite;
		gch = -1;
		gTx = 1'b0;
		for (int i = nU - 1; i >= 0; i--) begin
			if (mTxPend[i]) begin
				gch = i;
				gTx = 1'b1;
			end
		end
		if (gch < 0) begin
			for (int i = nU - 1; i >= 0; i--) begin
				if (mRxPend[i]) gch = i;
			end
		end
		expWrite = idle && (gch >= 0);
		if (expWrite) begin
			orderQ.push_back(gch);
			wordQ[gch].push_back(gTx ? refRecord(1'b1, 1'b0, mSent[gch])
				: refRecord(1'b0, mOvr[gch], mRxData[gch]));
			addrQ[gch].push_back(refAddr(gch, gTx));
		end
		for (int i = 0; i < nU; i++) begin
			expStart[i] = cpuWrite && (cpuAddress == txAddr(i)) && !uartTxBusy[i] && !mTxPend[i];
			if (expStart[i]) expByte = cpuWriteData;
			rise = uartRxReady[i] && !mRxPrev[i];
			fall = mBusyPrev[i] && !uartTxBusy[i];
			if (fall) begin
				mTxPend[i] = 1'b1;
				mSent[i] = mSent[i] + 8'd1;
			end else if (expWrite && gch == i && gTx) begin
				mTxPend[i] = 1'b0;
			end
			if (rise) begin
				mOvr[i] = mRxPend[i] && !(expWrite && gch == i && !gTx);
				mRxPend[i] = 1'b1;
				mRxData[i] = uartRxByte[i];
			end else if (expWrite && gch == i && !gTx) begin
				mRxPend[i] = 1'b0;
				mOvr[i] = 1'b0;
			end
			mRxPrev[i] = uartRxReady[i];
			mBusyPrev[i] = uartTxBusy[i];
		end
	endtask

	always @(negedge clk) begin
		if (rstN) begin
			compareStep();
			modelStep();
		end
	end

	// serializer model, busy for 2 to 9 cycles after each start
	always @(posedge clk) begin
		for (int i = 0; i < nU; i++) begin : uartTx
			logic [15:0] r;
			if (!rstN) begin
				busyCnt[i] <= 0;
				uartTxBusy[i] <= 1'b0;
			end else if (uartTxStart[i]) begin
				drawBits(3, r);
				busyCnt[i] <= 2 + int'(r[2:0]);
				uartTxBusy[i] <= 1'b1;
			end else if (busyCnt[i] > 0) begin
				busyCnt[i] <= busyCnt[i] - 1;
				if (busyCnt[i] == 1) uartTxBusy[i] <= 1'b0;
			end
		end
	end

	function automatic logic quiet();
		logic q;
		q = (orderQ.size() == 0) && !expWrite && (expStart == '0) && (uartTxStart == '0)
			&& (uartTxBusy == '0);
		for (int i = 0; i < nU; i++) begin
			q = q && !mRxPend[i] && !mTxPend[i];
		end
		return q;
	endfunction

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic drain();
		@(posedge clk);
		while (!quiet()) @(posedge clk);
		idleCycles(2);
	endtask

	task automatic cpuStore(input int ch, input logic [7:0] data);
		@(posedge clk);
		cpuRead <= 1'b0;
		cpuWrite <= 1'b1;
		cpuAddress <= txAddr(ch);
		cpuWriteData <= data;
		@(posedge clk);
		cpuWrite <= 1'b0;
	endtask

	task automatic rxEvent(input logic [nU-1:0] mask);
		logic [15:0] v;
		logic [15:0] len;
		@(posedge clk);
		for (int i = 0; i < nU; i++) begin
			drawBits(8, v);
			if (mask[i]) uartRxByte[i] <= v[7:0];
		end
		uartRxReady <= mask;
		drawBits(2, len);
		idleCycles(1 + int'(len[1:0]) % 3);
		uartRxReady <= '0;
	endtask

	task automatic finishTest(input int errBefore);
		if (errors == errBefore) begin
			passCount++;
			$display("test %s: ok", curTest);
		end else begin
			failCount++;
			$display("test %s: %0d errors", curTest, errors - errBefore);
		end
	endtask

	initial begin
		repeat (resetCycles + numTests * 200) @(posedge clk);
		$display("watchdog timeout, the run did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int e;
		logic [15:0] op;
		logic [15:0] v;
		clk = 1'b0;
		rstN = 1'b0;
		cpuAddress = '0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		cpuWriteData = '0;
		uartRxReady = '0;
		uartRxByte = '0;
		for (int i = 0; i < nU; i++) begin
			mRxPrev[i] = 1'b0;
			mBusyPrev[i] = 1'b0;
			mRxPend[i] = 1'b0;
			mTxPend[i] = 1'b0;
			mOvr[i] = 1'b0;
			mRxData[i] = '0;
			mSent[i] = '0;
		end
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		curTest = "txStart";
		e = errors;
		for (int ch = 0; ch < nU; ch++) begin
			cpuStore(ch, 8'hA0 + 8'(ch));
			idleCycles(1);
			cpuStore(ch, 8'h5A); // channel busy, dropped
		end
		drain();
		cpuStore(0, 8'h3C);
		@(posedge clk);
		cpuRead <= 1'b1; // hold the bus so the done record waits
		while (!uartTxBusy[0]) @(posedge clk);
		while (uartTxBusy[0]) @(posedge clk);
		cpuStore(0, 8'hC3); // done record pending, dropped
		drain();
		finishTest(e);

		curTest = "txDone";
		e = errors;
		for (int ch = 0; ch < nU; ch++) begin
			cpuStore(ch, 8'h11 * 8'(ch + 1));
			drain();
		end
		finishTest(e);

		curTest = "rxRecord";
		e = errors;
		rxEvent(2'b01);
		drain();
		rxEvent(2'b10);
		drain();
		finishTest(e);

		curTest = "overrun";
		e = errors;
		@(posedge clk);
		cpuRead <= 1'b1;
		rxEvent(2'b10);
		rxEvent(2'b10);
		idleCycles(2);
		cpuRead <= 1'b0;
		drain();
		finishTest(e);

		curTest = "priority";
		e = errors;
		cpuStore(0, 8'h77);
		cpuStore(1, 8'h88);
		@(posedge clk);
		cpuRead <= 1'b1;
		rxEvent(2'b11);
		idleCycles(2);
		while (uartTxBusy != '0 || uartTxStart != '0) @(posedge clk);
		idleCycles(1);
		cpuRead <= 1'b0;
		drain();
		finishTest(e);

		curTest = "randomMix";
		e = errors;
		repeat (25) begin
			drawBits(2, op);
			case (op[1:0])
				2'd0: begin
					drawBits(9, v);
					cpuStore(int'(v[8]), v[7:0]);
				end
				2'd1: begin
					drawBits(2, v);
					@(posedge clk);
					cpuRead <= 1'b1;
					idleCycles(1 + int'(v[1:0]));
					cpuRead <= 1'b0;
				end
				2'd2: begin
					drawBits(2, v);
					rxEvent((v[1:0] == 2'b00) ? 2'b01 : v[1:0]);
				end
				default: begin
					drawBits(2, v);
					idleCycles(1 + int'(v[1:0]));
				end
			endcase
		end
		drain();
		finishTest(e);

		for (int i = 0; i < nU; i++) begin
			if (wordQ[i].size() != 0 || addrQ[i].size() != 0) begin
				errors++;
				$display("channel %0d still has expected records that never arrived", i);
			end
		end
		$display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount, errors);
		if (errors == 0 && failCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/uartBusPkg.sv
hdl/uartChanIf.sv
hdl/cpuPortDecode.sv
hdl/uartChanTracker.sv
hdl/flagWriteArbiter.sv
hdl/uartBusBridge.sv
verif/uartBusBridge_chk.sv
verif/uartBusBridgeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= uartBusBridgeTb
FLIST ?= flist.f
OBJDIR ?= obj_dir

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJDIR)
